// ==== rtl/ssram_bist_macros.svh ====
`ifndef SSRAM_BIST_MACROS_SVH
`define SSRAM_BIST_MACROS_SVH

// sram address bus width, 512k words
`define SSRAM_ADDR_W 19

// data bus width, 32 data bits plus 4 parity bits
`define SSRAM_DATA_W 36

// beats per burst, linear order only
`define BURST_LEN 4

// trace memory index width, 256 entries
`define TRACE_DEPTH_W 8

`endif

// ==== rtl/ssram_bist_pkg.sv ====
`include "ssram_bist_macros.svh"

package ssram_bist_pkg;

	// one burst request from the sequencer
	typedef struct packed {
		logic write;
		logic [`SSRAM_ADDR_W-1:0] address;
		logic [15:0] key;
	} burst_cmd_t;

	// one beat returned by a read burst
	typedef struct packed {
		logic [$clog2(`BURST_LEN)-1:0] index;
		logic [`SSRAM_ADDR_W-1:0] address;
		logic [`SSRAM_DATA_W-1:0] data;
	} read_beat_t;

	// run result, held until the next start
	typedef struct packed {
		logic done;
		logic fail;
		logic [7:0] error_count;
		logic [`SSRAM_ADDR_W-1:0] first_error_address;
	} bist_status_t;

	typedef enum logic [1:0] {
		CTRL_IDLE,
		CTRL_WRITE,
		CTRL_READ,
		CTRL_DRAIN
	} ctrl_state_t;

	typedef enum logic [1:0] {
		SEQ_IDLE,
		SEQ_WRITE,
		SEQ_READ
	} seq_state_t;

	// key in the upper half, address in the lower half,
	// even parity per byte on top
	function automatic logic [`SSRAM_DATA_W-1:0] pattern_word(
		input logic [15:0] key,
		input logic [`SSRAM_ADDR_W-1:0] address
	);
		logic [31:0] payload;
		logic [3:0] parity;
		payload = {key, address[15:0]};
		for (int i = 0; i < 4; i++) begin
			parity[i] = ^payload[i*8 +: 8];
		end
		return {parity, payload};
	endfunction

endpackage

// ==== rtl/ssram_trace_ram.sv ====
`timescale 1ns/1ps
`include "ssram_bist_macros.svh"

module ssram_trace_ram (
	input logic clk,

	// write side, one entry per read beat
	input logic wr_en,
	input logic [`TRACE_DEPTH_W-1:0] wr_index,
	input logic [`SSRAM_DATA_W-1:0] wr_data,

	// read side, data one cycle after the index
	input logic [`TRACE_DEPTH_W-1:0] rd_index,
	output logic [`SSRAM_DATA_W-1:0] rd_data
);

	// index wraps, so the last 256 beats stay
	logic [`SSRAM_DATA_W-1:0] mem [1 << `TRACE_DEPTH_W];

	always_ff @(posedge clk) begin
		if (wr_en) begin
			mem[wr_index] <= wr_data;
		end
	end

	// registered read port
	always_ff @(posedge clk) begin
		rd_data <= mem[rd_index];
	end

endmodule

// ==== rtl/ssram_burst_ctrl.sv ====
`timescale 1ns/1ps
`include "ssram_bist_macros.svh"

module ssram_burst_ctrl
	import ssram_bist_pkg::*;
(
	input logic clk,
	input logic reset_n,

	// burst request, only taken while idle
	input logic cmd_valid,
	input burst_cmd_t cmd,

	output logic burst_done,
	output logic beat_valid,
	output read_beat_t beat,

	// sram pins
	output logic [`SSRAM_ADDR_W-1:0] ssram_address,
	output logic ssram_oe_n,
	output logic ssram_writeen_n,
	output logic [3:0] ssram_byteen_n,
	output logic ssram_adsc_n,
	output logic ssram_advance_n,
	output logic ssram_adsp_n,
	output logic ssram_globalw_n,
	output logic ssram_ce1_n,
	output logic ssram_ce2,
	output logic ssram_ce3_n,
	output logic ssram_clk,
	inout wire [`SSRAM_DATA_W-1:0] ssram_data
);

	localparam int BEAT_W = $clog2(`BURST_LEN);
	localparam logic [BEAT_W-1:0] LAST_BEAT = BEAT_W'(`BURST_LEN - 1);

	ctrl_state_t state;
	burst_cmd_t cmd_reg;
	logic [BEAT_W-1:0] beat_cnt;
	logic data_oe;
	logic [`SSRAM_DATA_W-1:0] data_reg;
	logic [`SSRAM_ADDR_W-1:0] next_address;
	logic rd_issue;
	logic [1:0] rd_pipe_valid;
	logic [1:0][BEAT_W-1:0] rd_pipe_index;
	logic rd_last_capture;

	// sram runs on our clock, unused controls held inactive
	assign ssram_clk = clk;
	assign ssram_adsp_n = 1'b1;
	assign ssram_globalw_n = 1'b1;
	assign ssram_ce1_n = 1'b0;
	assign ssram_ce2 = 1'b1;
	assign ssram_ce3_n = 1'b0;

	// bus driven during write beats only
	assign ssram_data = data_oe ? data_reg : {`SSRAM_DATA_W{1'bz}};

	// address of the following write beat
	assign next_address = cmd_reg.address + `SSRAM_ADDR_W'(beat_cnt) + 1'b1;

	// one read beat requested per cycle in the read state
	assign rd_issue = (state == CTRL_READ);

	// data of the final beat is on the bus this cycle
	assign rd_last_capture = rd_pipe_valid[1] && (rd_pipe_index[1] == LAST_BEAT);

	always_ff @(posedge clk or negedge reset_n) begin
		if (!reset_n) begin
			state <= CTRL_IDLE;
			beat_cnt <= '0;
			ssram_address <= '0;
			ssram_adsc_n <= 1'b1;
			ssram_advance_n <= 1'b1;
			ssram_oe_n <= 1'b1;
			ssram_writeen_n <= 1'b1;
			ssram_byteen_n <= 4'b1111;
			data_oe <= 1'b0;
			burst_done <= 1'b0;
		end else begin
			burst_done <= 1'b0;
			case (state)
				CTRL_IDLE: begin
					beat_cnt <= '0;
					if (cmd_valid) begin
						// address phase, write data goes out with it
						ssram_address <= cmd.address;
						ssram_adsc_n <= 1'b0;
						ssram_byteen_n <= 4'b0000;
						ssram_writeen_n <= ~cmd.write;
						data_oe <= cmd.write;
						state <= cmd.write ? CTRL_WRITE : CTRL_READ;
					end
				end
				CTRL_WRITE, CTRL_READ: begin
					if (beat_cnt == LAST_BEAT) begin
						// pins back to idle after the fourth beat
						ssram_address <= '0;
						ssram_adsc_n <= 1'b1;
						ssram_advance_n <= 1'b1;
						ssram_writeen_n <= 1'b1;
						ssram_byteen_n <= 4'b1111;
						data_oe <= 1'b0;
						if (state == CTRL_WRITE) begin
							burst_done <= 1'b1;
							state <= CTRL_IDLE;
						end else begin
							state <= CTRL_DRAIN;
						end
					end else begin
						// burst counter inside the sram steps the address
						beat_cnt <= beat_cnt + 1'b1;
						ssram_adsc_n <= 1'b1;
						ssram_advance_n <= 1'b0;
					end
					// output enable from the cycle after the address
					if (state == CTRL_READ) begin
						ssram_oe_n <= 1'b0;
					end
				end
				CTRL_DRAIN: begin
					// wait for the pipeline to hand back the last beat
					if (rd_last_capture) begin
						ssram_oe_n <= 1'b1;
						burst_done <= 1'b1;
						state <= CTRL_IDLE;
					end
				end
				default: begin
					state <= CTRL_IDLE;
				end
			endcase
		end
	end

	// request copy and write word for the next beat
	always_ff @(posedge clk) begin
		if (state == CTRL_IDLE && cmd_valid) begin
			cmd_reg <= cmd;
			data_reg <= pattern_word(cmd.key, cmd.address);
		end else if (state == CTRL_WRITE) begin
			data_reg <= pattern_word(cmd_reg.key, next_address);
		end
	end

	// two stage delay matches the sram read latency
	always_ff @(posedge clk or negedge reset_n) begin
		if (!reset_n) begin
			rd_pipe_valid <= '0;
		end else begin
			rd_pipe_valid <= {rd_pipe_valid[0], rd_issue};
		end
	end

	always_ff @(posedge clk) begin
		rd_pipe_index <= {rd_pipe_index[0], beat_cnt};
	end

	always_ff @(posedge clk or negedge reset_n) begin
		if (!reset_n) begin
			beat_valid <= 1'b0;
		end else begin
			beat_valid <= rd_pipe_valid[1];
		end
	end

	// sample the bus at the end of the data cycle
	always_ff @(posedge clk) begin
		if (rd_pipe_valid[1]) begin
			beat.index <= rd_pipe_index[1];
			beat.address <= cmd_reg.address + `SSRAM_ADDR_W'(rd_pipe_index[1]);
			beat.data <= ssram_data;
		end
	end

endmodule

// ==== rtl/ssram_pattern_seq.sv ====
`timescale 1ns/1ps
`include "ssram_bist_macros.svh"

module ssram_pattern_seq
	import ssram_bist_pkg::*;
(
	input logic clk,
	input logic reset_n,

	// run parameters, sampled on start
	input logic start,
	input logic [`SSRAM_ADDR_W-1:0] base_address,
	input logic [7:0] burst_count,
	input logic [15:0] pattern_key,

	// from the burst controller
	input logic burst_done,
	input logic beat_valid,
	input read_beat_t beat,

	output logic cmd_valid,
	output burst_cmd_t cmd,
	output logic [`TRACE_DEPTH_W-1:0] trace_wr_index,
	output bist_status_t status
);

	seq_state_t state;
	logic [`SSRAM_ADDR_W-1:0] base_reg;
	logic [7:0] count_reg;
	logic [7:0] burst_idx;
	logic last_burst;
	logic launch;
	logic next_burst;
	logic next_pass;
	logic finish;
	logic [`SSRAM_DATA_W-1:0] expected;
	logic mismatch;

	// zero count wraps to 255 here, giving 256 bursts
	assign last_burst = (burst_idx == count_reg - 8'd1);

	assign launch = (state == SEQ_IDLE) && start;
	assign next_burst = (state != SEQ_IDLE) && burst_done && !last_burst;
	assign next_pass = (state == SEQ_WRITE) && burst_done && last_burst;
	assign finish = (state == SEQ_READ) && burst_done && last_burst;

	// expected word from the address the beat came from
	assign expected = pattern_word(cmd.key, beat.address);
	assign mismatch = beat_valid && (state == SEQ_READ) && (beat.data != expected);

	always_ff @(posedge clk or negedge reset_n) begin
		if (!reset_n) begin
			state <= SEQ_IDLE;
			burst_idx <= '0;
			cmd_valid <= 1'b0;
		end else begin
			// one cycle pulse per burst
			cmd_valid <= launch || next_burst || next_pass;
			if (launch) begin
				burst_idx <= '0;
				state <= SEQ_WRITE;
			end else if (next_pass) begin
				burst_idx <= '0;
				state <= SEQ_READ;
			end else if (next_burst) begin
				burst_idx <= burst_idx + 8'd1;
			end else if (finish) begin
				state <= SEQ_IDLE;
			end
		end
	end

	// run parameters and the request payload
	always_ff @(posedge clk) begin
		if (launch) begin
			base_reg <= base_address;
			count_reg <= burst_count;
			cmd.write <= 1'b1;
			cmd.address <= base_address;
			cmd.key <= pattern_key;
		end else if (next_pass) begin
			// read pass restarts from the base
			cmd.write <= 1'b0;
			cmd.address <= base_reg;
		end else if (next_burst) begin
			cmd.address <= cmd.address + `SSRAM_ADDR_W'(`BURST_LEN);
		end
	end

	// trace slot for each read beat
	always_ff @(posedge clk or negedge reset_n) begin
		if (!reset_n) begin
			trace_wr_index <= '0;
		end else if (launch) begin
			trace_wr_index <= '0;
		end else if (beat_valid) begin
			trace_wr_index <= trace_wr_index + 1'b1;
		end
	end

	// registered compare, count is one cycle behind the beat
	always_ff @(posedge clk or negedge reset_n) begin
		if (!reset_n) begin
			status <= '0;
		end else if (launch) begin
			status <= '0;
		end else begin
			if (mismatch) begin
				// count stops at 255
				if (status.error_count != 8'hff) begin
					status.error_count <= status.error_count + 8'd1;
				end
				// keep the address of the first miss only
				if (!status.fail) begin
					status.first_error_address <= beat.address;
				end
				status.fail <= 1'b1;
			end
			if (finish) begin
				status.done <= 1'b1;
			end
		end
	end

endmodule

// ==== rtl/ssram_bist_top.sv ====
`timescale 1ns/1ps
`include "ssram_bist_macros.svh"

module ssram_bist_top
	import ssram_bist_pkg::*;
(
	input logic clk,
	input logic reset_n,

	// run control
	input logic start,
	input logic [`SSRAM_ADDR_W-1:0] base_address,
	input logic [7:0] burst_count,
	input logic [15:0] pattern_key,
	input logic [`TRACE_DEPTH_W-1:0] trace_index,

	// sram pins
	output logic [`SSRAM_ADDR_W-1:0] ssram_address,
	output logic ssram_oe_n,
	output logic ssram_writeen_n,
	output logic [3:0] ssram_byteen_n,
	output logic ssram_adsc_n,
	output logic ssram_advance_n,
	output logic ssram_adsp_n,
	output logic ssram_globalw_n,
	output logic ssram_ce1_n,
	output logic ssram_ce2,
	output logic ssram_ce3_n,
	output logic ssram_clk,
	inout wire [`SSRAM_DATA_W-1:0] ssram_data,

	// results
	output bist_status_t status,
	output logic [`SSRAM_DATA_W-1:0] trace_data
);

	logic cmd_valid;
	burst_cmd_t cmd;
	logic burst_done;
	logic beat_valid;
	read_beat_t beat;
	logic [`TRACE_DEPTH_W-1:0] trace_wr_index;

	// write pass, read pass and compare
	ssram_pattern_seq i_seq (
		.clk(clk),
		.reset_n(reset_n),
		.start(start),
		.base_address(base_address),
		.burst_count(burst_count),
		.pattern_key(pattern_key),
		.burst_done(burst_done),
		.beat_valid(beat_valid),
		.beat(beat),
		.cmd_valid(cmd_valid),
		.cmd(cmd),
		.trace_wr_index(trace_wr_index),
		.status(status)
	);

	// pin level burst timing
	ssram_burst_ctrl i_ctrl (
		.clk(clk),
		.reset_n(reset_n),
		.cmd_valid(cmd_valid),
		.cmd(cmd),
		.burst_done(burst_done),
		.beat_valid(beat_valid),
		.beat(beat),
		.ssram_address(ssram_address),
		.ssram_oe_n(ssram_oe_n),
		.ssram_writeen_n(ssram_writeen_n),
		.ssram_byteen_n(ssram_byteen_n),
		.ssram_adsc_n(ssram_adsc_n),
		.ssram_advance_n(ssram_advance_n),
		.ssram_adsp_n(ssram_adsp_n),
		.ssram_globalw_n(ssram_globalw_n),
		.ssram_ce1_n(ssram_ce1_n),
		.ssram_ce2(ssram_ce2),
		.ssram_ce3_n(ssram_ce3_n),
		.ssram_clk(ssram_clk),
		.ssram_data(ssram_data)
	);

	// read beat history
	ssram_trace_ram i_trace (
		.clk(clk),
		.wr_en(beat_valid),
		.wr_index(trace_wr_index),
		.wr_data(beat.data),
		.rd_index(trace_index),
		.rd_data(trace_data)
	);

endmodule

// ==== test/ssram_model.sv ====
`timescale 1ns/1ps
`include "ssram_bist_macros.svh"

module ssram_model (
	input logic clk,
	input logic [`SSRAM_ADDR_W-1:0] address,
	input logic adsc_n,
	input logic advance_n,
	input logic oe_n,
	input logic writeen_n,
	input logic [3:0] byteen_n,
	inout wire [`SSRAM_DATA_W-1:0] data,

	// fault injection, bit 0 of one word flips on the way out
	input logic corrupt_en,
	input logic [`SSRAM_ADDR_W-1:0] corrupt_address
);

	logic [`SSRAM_DATA_W-1:0] mem [1 << `SSRAM_ADDR_W];
	logic [`SSRAM_ADDR_W-1:0] burst_address;
	logic [`SSRAM_ADDR_W-1:0] access_address;
	logic access;
	logic [`SSRAM_DATA_W-1:0] write_word;
	logic [`SSRAM_DATA_W-1:0] stage_data;
	logic stage_valid;
	logic [`SSRAM_DATA_W-1:0] out_data;
	logic out_valid;

	// adsc loads the address, advance steps the internal counter
	assign access = !adsc_n || !advance_n;
	assign access_address = !adsc_n ? address : burst_address + 1'b1;

	// outputs only when enabled and a read word is ready
	assign data = (!oe_n && out_valid) ? out_data : {`SSRAM_DATA_W{1'bz}};

	// byte lane merge, each lane is 8 data bits plus its parity bit
	always_comb begin
		write_word = mem[access_address];
		for (int i = 0; i < 4; i++) begin
			if (!byteen_n[i]) begin
				write_word[i*8 +: 8] = data[i*8 +: 8];
				write_word[32 + i] = data[32 + i];
			end
		end
	end

	always @(posedge clk) begin
		if (access) begin
			burst_address <= access_address;
		end
		if (access && !writeen_n) begin
			mem[access_address] <= write_word;
		end
	end

	// pipelined read, word on the bus two cycles after its address
	always @(posedge clk) begin
		stage_valid <= access && writeen_n;
		if (corrupt_en && access_address == corrupt_address) begin
			stage_data <= mem[access_address] ^ `SSRAM_DATA_W'(1);
		end else begin
			stage_data <= mem[access_address];
		end
		out_valid <= stage_valid;
		out_data <= stage_data;
	end

endmodule

// ==== test/ssram_bist_assert.sv ====
`timescale 1ns/1ps

module ssram_bist_assert (
	input logic clk,
	input logic reset_n,
	input logic ssram_adsc_n,
	input logic ssram_advance_n,
	input logic ssram_oe_n,
	input logic ssram_writeen_n,
	input logic [3:0] ssram_byteen_n,
	input logic ssram_adsp_n,
	input logic ssram_globalw_n,
	input logic ssram_ce1_n,
	input logic ssram_ce2,
	input logic ssram_ce3_n,
	input logic bus_driven
);

	// one sticky flag per property
	logic [4:0] violations;

	initial begin
		violations = '0;
	end

	// strobes idle and bus released in reset
	reset_idle: assert property (@(posedge clk)
		!reset_n |-> ssram_adsc_n && ssram_advance_n && ssram_oe_n && ssram_writeen_n
			&& ssram_byteen_n == 4'b1111 && !bus_driven)
	else begin
		violations[0] = 1'b1;
		$error("sram strobes active or bus driven during reset");
	end

	// address phase, then exactly three advance cycles
	burst_shape: assert property (@(posedge clk) disable iff (!reset_n)
		!ssram_adsc_n |=> !ssram_advance_n ##1 !ssram_advance_n ##1 !ssram_advance_n
			##1 ssram_advance_n)
	else begin
		violations[1] = 1'b1;
		$error("adsc not followed by three advance cycles");
	end

	// write strobe only with our data on the bus
	write_drive: assert property (@(posedge clk) disable iff (!reset_n)
		!ssram_writeen_n |-> bus_driven)
	else begin
		violations[2] = 1'b1;
		$error("write strobe without bus drive");
	end

	// output enable held off while the controller drives the bus
	no_contention: assert property (@(posedge clk) disable iff (!reset_n)
		bus_driven |-> ssram_oe_n)
	else begin
		violations[3] = 1'b1;
		$error("output enable low while the controller drives the bus");
	end

	// adsp path and global write off, chip always selected
	tie_offs: assert property (@(posedge clk) disable iff (!reset_n)
		ssram_adsp_n && ssram_globalw_n && !ssram_ce1_n && ssram_ce2 && !ssram_ce3_n)
	else begin
		violations[4] = 1'b1;
		$error("unused sram controls not at their fixed levels");
	end

endmodule

bind ssram_bist_top ssram_bist_assert i_assert (
	.clk(clk),
	.reset_n(reset_n),
	.ssram_adsc_n(ssram_adsc_n),
	.ssram_advance_n(ssram_advance_n),
	.ssram_oe_n(ssram_oe_n),
	.ssram_writeen_n(ssram_writeen_n),
	.ssram_byteen_n(ssram_byteen_n),
	.ssram_adsp_n(ssram_adsp_n),
	.ssram_globalw_n(ssram_globalw_n),
	.ssram_ce1_n(ssram_ce1_n),
	.ssram_ce2(ssram_ce2),
	.ssram_ce3_n(ssram_ce3_n),
	.bus_driven(i_ctrl.data_oe)
);

// ==== test/tb_ssram_bist.sv ====
`timescale 1ns/1ps
`include "ssram_bist_macros.svh"

module tb_ssram_bist
	import ssram_bist_pkg::*;
();

	// a full 256 burst run takes about 3600 cycles
	localparam int RUN_TIMEOUT = 20000;

	logic clk;
	logic reset_n;
	logic start;
	logic [`SSRAM_ADDR_W-1:0] base_address;
	logic [7:0] burst_count;
	logic [15:0] pattern_key;
	logic [`TRACE_DEPTH_W-1:0] trace_index;
	logic corrupt_en;
	logic [`SSRAM_ADDR_W-1:0] corrupt_address;

	logic [`SSRAM_ADDR_W-1:0] ssram_address;
	logic ssram_oe_n;
	logic ssram_writeen_n;
	logic [3:0] ssram_byteen_n;
	logic ssram_adsc_n;
	logic ssram_advance_n;
	logic ssram_adsp_n;
	logic ssram_globalw_n;
	logic ssram_ce1_n;
	logic ssram_ce2;
	logic ssram_ce3_n;
	logic ssram_clk;
	wire [`SSRAM_DATA_W-1:0] ssram_data;
	bist_status_t status;
	logic [`SSRAM_DATA_W-1:0] trace_data;

	ssram_bist_top i_dut (.*);

	ssram_model i_sram (
		.clk(ssram_clk),
		.address(ssram_address),
		.adsc_n(ssram_adsc_n),
		.advance_n(ssram_advance_n),
		.oe_n(ssram_oe_n),
		.writeen_n(ssram_writeen_n),
		.byteen_n(ssram_byteen_n),
		.data(ssram_data),
		.corrupt_en(corrupt_en),
		.corrupt_address(corrupt_address)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	// key on top, low address bits below, even parity per byte
	function automatic logic [`SSRAM_DATA_W-1:0] expected_word(
		input logic [15:0] key,
		input logic [`SSRAM_ADDR_W-1:0] address
	);
		logic [31:0] low;
		logic [3:0] par;
		low = {key, address[15:0]};
		par[0] = ^low[7:0];
		par[1] = ^low[15:8];
		par[2] = ^low[23:16];
		par[3] = ^low[31:24];
		return {par, low};
	endfunction

	task automatic stop_with_failure();
		$display("SIMULATION FAILED");
		$fatal(1, "stopped at the first error");
	endtask

	// done polled on the falling edge, away from register updates
	task automatic wait_for_done();
		int cycles;
		cycles = 0;
		while (!status.done) begin
			@(negedge clk);
			cycles++;
			if (cycles > RUN_TIMEOUT) begin
				$display("timeout: run not done after %0d cycles", RUN_TIMEOUT);
				stop_with_failure();
			end
		end
	endtask

	// start pulse, status must clear, then wait for done
	task automatic run_bist(
		input logic [15:0] key,
		input logic [`SSRAM_ADDR_W-1:0] base,
		input logic [7:0] count
	);
		@(posedge clk);
		pattern_key <= key;
		base_address <= base;
		burst_count <= count;
		start <= 1'b1;
		@(posedge clk);
		start <= 1'b0;
		@(negedge clk);
		assert (!status.done && !status.fail && status.error_count == 8'd0) else begin
			$display("[ERROR] %0t status not cleared by start: done=%0b fail=%0b errors=%0d",
				$time, status.done, status.fail, status.error_count);
			stop_with_failure();
		end
		wait_for_done();
	endtask

	task automatic check_clean();
		assert (status.done && !status.fail && status.error_count == 8'd0) else begin
			$display("[ERROR] %0t clean run: done=%0b fail=%0b errors=%0d",
				$time, status.done, status.fail, status.error_count);
			stop_with_failure();
		end
	endtask

	task automatic check_fault(input logic [`SSRAM_ADDR_W-1:0] bad_address);
		assert (status.done && status.fail && status.error_count == 8'd1
			&& status.first_error_address == bad_address) else begin
			$display("[ERROR] %0t fault run: fail=%0b errors=%0d first=%h expected %h",
				$time, status.fail, status.error_count, status.first_error_address,
				bad_address);
			stop_with_failure();
		end
	endtask

	// trace slot j keeps the latest read beat whose number is j mod 256
	task automatic check_trace(
		input logic [15:0] key,
		input logic [`SSRAM_ADDR_W-1:0] base,
		input logic [7:0] count
	);
		int beats;
		int shown;
		int b;
		logic [`SSRAM_ADDR_W-1:0] address;
		beats = (count == 8'd0) ? 1024 : 4 * count;
		shown = (beats > 256) ? 256 : beats;
		for (int j = 0; j < shown; j++) begin
			b = j + 256 * ((beats - 1 - j) / 256);
			address = base + `SSRAM_ADDR_W'(b);
			@(posedge clk);
			trace_index <= `TRACE_DEPTH_W'(j);
			// registered read port, data one edge later
			@(posedge clk);
			@(negedge clk);
			assert (trace_data == expected_word(key, address)) else begin
				$display("[ERROR] %0t trace[%0d] = %h, expected %h",
					$time, j, trace_data, expected_word(key, address));
				stop_with_failure();
			end
		end
	endtask

	// early stop when the bound checker flags the pins
	always @(negedge clk) begin
		if (i_dut.i_assert.violations != '0) begin
			$display("a protocol assertion on the SRAM pins failed");
			stop_with_failure();
		end
	end

	initial begin
		logic [15:0] key;
		logic [`SSRAM_ADDR_W-1:0] base;
		logic [7:0] count;
		logic [`SSRAM_ADDR_W-1:0] bad_address;
		void'($urandom(32'h1d66d2db));
		reset_n = 1'b1;
		start = 1'b0;
		base_address = '0;
		burst_count = '0;
		pattern_key = '0;
		trace_index = '0;
		corrupt_en = 1'b0;
		corrupt_address = '0;
		// falling reset edge before the first clock
		reset_n <= 1'b0;
		repeat (2) @(posedge clk);
		reset_n <= 1'b1;

		// clean run, random parameters
		key = 16'($urandom());
		base = `SSRAM_ADDR_W'($urandom());
		count = 8'($urandom_range(64, 1));
		run_bist(key, base, count);
		check_clean();
		check_trace(key, base, count);

		// one corrupted word inside the tested range
		key = 16'($urandom());
		base = `SSRAM_ADDR_W'($urandom());
		count = 8'($urandom_range(16, 1));
		bad_address = base + `SSRAM_ADDR_W'($urandom_range(4 * count - 1));
		@(posedge clk);
		corrupt_en <= 1'b1;
		corrupt_address <= bad_address;
		run_bist(key, base, count);
		check_fault(bad_address);
		@(posedge clk);
		corrupt_en <= 1'b0;

		// restart with a new key, 256 bursts so the trace wraps
		key = 16'($urandom());
		base = `SSRAM_ADDR_W'($urandom());
		count = 8'd0;
		run_bist(key, base, count);
		check_clean();
		check_trace(key, base, count);

		@(negedge clk);
		if (i_dut.i_assert.violations != '0) begin
			$display("a protocol assertion on the SRAM pins failed");
			stop_with_failure();
		end else begin
			$display("SIMULATION PASSED");
			$finish;
		end
	end

endmodule

// ==== sim.f ====
+incdir+rtl
rtl/ssram_bist_pkg.sv
rtl/ssram_trace_ram.sv
rtl/ssram_burst_ctrl.sv
rtl/ssram_pattern_seq.sv
rtl/ssram_bist_top.sv
test/ssram_model.sv
test/ssram_bist_assert.sv
test/tb_ssram_bist.sv

// ==== Makefile ====
LOG = sim.log

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f sim.f --top-module tb_ssram_bist

sim:
	verilator --binary --timing --assert -f sim.f --top-module tb_ssram_bist -Mdir obj_dir
	./obj_dir/Vtb_ssram_bist | tee $(LOG)
	grep -q "^SIMULATION PASSED$$" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
